//--- verilog.f
design/axi_xbar_pkg.sv
design/aw_if.sv
design/aw_addr_decoder.sv
design/aw_arbiter.sv
design/write_address_channel.sv
design/aw_xbar_top.sv
bench/aw_xbar_tb.sv

//--- bench/aw_xbar_stimulus.txt
# name then per master 0..2: en id addr len size burst (hex), then ready delay for slaves 0..3,
# then count of accepted requests and three pairs of master and slave (unmapped, none if unused)
single_s0 1 3 00001000 7 2 1  0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 0 0 0  1 0 0 0 none 0 none
single_s1 0 0 00000000 0 0 0  1 5 00010040 3 3 1  0 0 00000000 0 0 0  0 0 0 0  1 1 1 0 none 0 none
single_s2 0 0 00000000 0 0 0  0 0 00000000 0 0 0  1 a 12345678 f 1 2  0 0 0 0  1 2 2 0 none 0 none
single_s3 1 f 20000100 1 2 0  0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 0 0 0  1 0 3 0 none 0 none
unmapped_m1 0 0 00000000 0 0 0  1 6 00020000 2 2 1  0 0 00000000 0 0 0  0 0 0 0  1 1 unmapped 0 none 0 none
all_three 1 1 0000abc0 0 3 1  1 2 1fff0000 4 2 1  1 3 2ff00000 8 2 1  0 0 0 0  3 2 3 0 0 1 2
delay_s2 1 9 10000000 5 2 1  0 0 00000000 0 0 0  0 0 00000000 0 0 0  0 0 5 0  1 0 2 0 none 0 none
two_masters 0 0 00000000 0 0 0  1 4 0000fffc 0 2 0  1 c 2abcdef0 3 1 1  2 0 0 1  2 1 0 2 3 0 none
mixed_unmapped 1 7 0001ff00 1 2 1  1 8 30000000 2 2 1  1 b 1000beef 6 0 2  1 1 3 0  3 0 1 1 unmapped 2 2
rr_wrap 0 0 00000000 0 0 0  1 d 00018000 7 3 1  1 e 00010010 2 2 1  0 0 0 0  2 1 1 2 1 0 none
delay_all 1 4 2f000000 3 2 1  1 5 1c000000 1 2 1  1 6 00011100 0 2 0  4 4 4 4  3 0 3 1 2 2 1
unmapped_m2 0 0 00000000 0 0 0  0 0 00000000 0 0 0  1 2 fffffff0 0 2 1  0 0 0 0  1 2 unmapped 0 none 0 none

//--- bench/aw_xbar_tb.sv
`timescale 1ns/1ns
`default_nettype none

module aw_xbar_tb;
	import axi_xbar_pkg::*;

	localparam int MAX_TESTS = 32;
	localparam int FLD_W = $bits(axi_ids_t) + ADDR_BITS + LEN_BITS + SIZE_BITS + 2;

	typedef struct packed {
		logic        decerr;
		master_idx_t mst;
		slave_idx_t  slv;
		axi_ids_t    ids;
		axi_addr_t   addr;
		axi_len_t    len;
		axi_size_t   size;
		axi_burst_t  burst;
	} xfer_t;

	logic        aclk;
	logic        rst_n;
	axi_id_t     m_awid    [NUM_MASTERS];
	axi_addr_t   m_awaddr  [NUM_MASTERS];
	axi_len_t    m_awlen   [NUM_MASTERS];
	axi_size_t   m_awsize  [NUM_MASTERS];
	axi_burst_t  m_awburst [NUM_MASTERS];
	logic        m_awvalid [NUM_MASTERS];
	logic        m_awready [NUM_MASTERS];
	axi_ids_t    s_awid    [NUM_SLAVES];
	axi_addr_t   s_awaddr  [NUM_SLAVES];
	axi_len_t    s_awlen   [NUM_SLAVES];
	axi_size_t   s_awsize  [NUM_SLAVES];
	axi_burst_t  s_awburst [NUM_SLAVES];
	logic        s_awvalid [NUM_SLAVES];
	logic        s_awready [NUM_SLAVES];
	logic        decerr;
	master_idx_t decerr_master;

	// Tests loaded from the stimulus file
	string       t_name  [MAX_TESTS];
	logic        t_en    [MAX_TESTS][NUM_MASTERS];
	axi_id_t     t_id    [MAX_TESTS][NUM_MASTERS];
	axi_addr_t   t_addr  [MAX_TESTS][NUM_MASTERS];
	axi_len_t    t_len   [MAX_TESTS][NUM_MASTERS];
	axi_size_t   t_size  [MAX_TESTS][NUM_MASTERS];
	axi_burst_t  t_burst [MAX_TESTS][NUM_MASTERS];
	int          t_delay [MAX_TESTS][NUM_SLAVES];
	int          t_nexp  [MAX_TESTS];
	master_idx_t t_emst  [MAX_TESTS][NUM_MASTERS];
	// Expected slave with -1 for unmapped and -2 for unused
	int          t_eslv  [MAX_TESTS][NUM_MASTERS];
	int          num_tests;
	int          max_delay;
	logic        loaded;
	int          errors;
	int          cur_delay [NUM_SLAVES];
	xfer_t       seen [$];

	aw_xbar_top i_dut (.*);

	always #50 aclk = ~aclk;

	task automatic check_slave(input string name, input slave_idx_t exp, input slave_idx_t act);
		if (exp !== act) begin
			$display("ERROR %s: slave expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_ids(input string name, input axi_ids_t exp, input axi_ids_t act);
		if (exp !== act) begin
			$display("ERROR %s: slave id expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input axi_addr_t exp, input axi_addr_t act);
		if (exp !== act) begin
			$display("ERROR %s: address expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_master(input string name, input master_idx_t exp,
			input master_idx_t act);
		if (exp !== act) begin
			$display("ERROR %s: master expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_attrs(input string name, input axi_len_t el, input axi_size_t es,
			input axi_burst_t eb, input axi_len_t al, input axi_size_t as,
			input axi_burst_t ab);
		if ({el, es, eb} !== {al, as, ab}) begin
			$display("ERROR %s: len/size/burst expected %h/%h/%h actual %h/%h/%h",
				name, el, es, eb, al, as, ab);
			errors++;
		end
	endtask

	task automatic load_tests();
		int          fd;
		string       tok;
		string       line;
		logic [31:0] v [6];
		int          n;

		fd = $fopen("bench/aw_xbar_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			errors++;
			return;
		end
		while (!$feof(fd) && num_tests < MAX_TESTS) begin
			if ($fscanf(fd, "%s", tok) != 1) break;
			if (tok[0] == 8'h23) begin
				void'($fgets(line, fd));
				continue;
			end
			t_name[num_tests] = tok;
			for (int m = 0; m < NUM_MASTERS; m++) begin
				void'($fscanf(fd, "%h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]));
				t_en[num_tests][m]    = v[0][0];
				t_id[num_tests][m]    = axi_id_t'(v[1]);
				t_addr[num_tests][m]  = v[2];
				t_len[num_tests][m]   = axi_len_t'(v[3]);
				t_size[num_tests][m]  = axi_size_t'(v[4]);
				t_burst[num_tests][m] = axi_burst_t'(v[5]);
			end
			for (int s = 0; s < NUM_SLAVES; s++) begin
				void'($fscanf(fd, "%d", t_delay[num_tests][s]));
				if (t_delay[num_tests][s] > max_delay) max_delay = t_delay[num_tests][s];
			end
			void'($fscanf(fd, "%d", t_nexp[num_tests]));
			for (int i = 0; i < NUM_MASTERS; i++) begin
				void'($fscanf(fd, "%d %s", n, tok));
				t_emst[num_tests][i] = master_idx_t'(n);
				if (tok == "unmapped") t_eslv[num_tests][i] = -1;
				else if (tok == "none") t_eslv[num_tests][i] = -2;
				else t_eslv[num_tests][i] = tok.atoi();
			end
			num_tests++;
		end
		$fclose(fd);
		if (num_tests == 0) begin
			$display("no tests found in the stimulus file");
			errors++;
		end
	endtask

	task automatic run_test(input int t);
		logic        pending;
		int          gap;
		xfer_t       e;
		master_idx_t m;

		seen.delete();
		for (int s = 0; s < NUM_SLAVES; s++) cur_delay[s] = t_delay[t][s];
		@(posedge aclk);
		for (int i = 0; i < NUM_MASTERS; i++) begin
			m_awid[i]    <= t_id[t][i];
			m_awaddr[i]  <= t_addr[t][i];
			m_awlen[i]   <= t_len[t][i];
			m_awsize[i]  <= t_size[t][i];
			m_awburst[i] <= t_burst[t][i];
			m_awvalid[i] <= t_en[t][i];
		end
		// Each master holds valid until its handshake
		do begin
			@(posedge aclk);
			pending = 1'b0;
			for (int i = 0; i < NUM_MASTERS; i++) begin
				if (m_awvalid[i] && m_awready[i]) m_awvalid[i] <= 1'b0;
				else if (m_awvalid[i]) pending = 1'b1;
			end
		end while (pending);
		repeat (2) @(posedge aclk);

		if (seen.size() != t_nexp[t]) begin
			$display("ERROR %s: accepted requests expected %0d actual %0d",
				t_name[t], t_nexp[t], seen.size());
			errors++;
		end else begin
			for (int i = 0; i < t_nexp[t]; i++) begin
				e = seen[i];
				m = t_emst[t][i];
				check_master(t_name[t], m, e.mst);
				if (t_eslv[t][i] < 0 && !e.decerr) begin
					$display("%s: request %0d reached a slave instead of a decode error",
						t_name[t], i);
					errors++;
				end else if (t_eslv[t][i] >= 0 && e.decerr) begin
					$display("%s: request %0d got an unexpected decode error", t_name[t], i);
					errors++;
				end else if (t_eslv[t][i] >= 0) begin
					check_slave(t_name[t], slave_idx_t'(t_eslv[t][i]), e.slv);
					check_ids(t_name[t], {m, t_id[t][m]}, e.ids);
					check_addr(t_name[t], t_addr[t][m], e.addr);
					check_attrs(t_name[t], t_len[t][m], t_size[t][m], t_burst[t][m],
						e.len, e.size, e.burst);
				end
			end
		end
		gap = $urandom % 4;
		repeat (gap) @(posedge aclk);
	endtask

	// Slave models raise ready after their delay
	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
		int wait_cnt;

		always @(posedge aclk) begin
			if (!rst_n) begin
				s_awready[s] <= 1'b0;
				wait_cnt = 0;
			end else if (s_awvalid[s] && s_awready[s]) begin
				s_awready[s] <= 1'b0;
				wait_cnt = 0;
			end else if (s_awvalid[s]) begin
				if (wait_cnt >= cur_delay[s]) s_awready[s] <= 1'b1;
				else wait_cnt++;
			end
		end
	end

	// Monitor of handshakes, decode errors and stalled requests
	logic             stalled [NUM_SLAVES];
	logic [FLD_W-1:0] held    [NUM_SLAVES];

	always @(posedge aclk) begin
		int               nvalid;
		int               nready;
		logic [FLD_W-1:0] fld;

		if (!rst_n) begin
			for (int s = 0; s < NUM_SLAVES; s++) stalled[s] = 1'b0;
		end else begin
			nvalid = 0;
			nready = 0;
			for (int s = 0; s < NUM_SLAVES; s++) begin
				fld = {s_awid[s], s_awaddr[s], s_awlen[s], s_awsize[s], s_awburst[s]};
				if (stalled[s] && (!s_awvalid[s] || fld !== held[s])) begin
					$display("slave %0d request changed before it was accepted", s);
					errors++;
				end
				if (s_awvalid[s]) begin
					nvalid++;
					if (s_awready[s]) begin
						seen.push_back({1'b0, s_awid[s][ID_BITS +: MID_BITS],
							slave_idx_t'(s), fld});
					end
				end else if (fld !== '0) begin
					$display("idle slave %0d sees nonzero fields", s);
					errors++;
				end
				stalled[s] = s_awvalid[s] && !s_awready[s];
				held[s]    = fld;
			end
			for (int m = 0; m < NUM_MASTERS; m++) begin
				if (m_awready[m]) nready++;
			end
			if (nvalid > 1 || nready > 1) begin
				$display("more than one slave valid or master ready in one cycle");
				errors++;
			end
			if (decerr) begin
				seen.push_back({1'b1, decerr_master, {(SID_BITS + FLD_W){1'b0}}});
				if (!m_awready[decerr_master]) begin
					$display("decode error without ready to master %0d", decerr_master);
					errors++;
				end
			end
		end
	end

	// Up to delay + 3 cycles per transfer and a few more per test
	initial begin
		int limit;

		wait (loaded);
		limit = num_tests * (3 * (max_delay + 3) + 8) + 4;
		repeat (limit) @(posedge aclk);
		$display("watchdog expired after %0d cycles, the run hung", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h42f7_ffc6));
		aclk      = 1'b0;
		rst_n     = 1'b0;
		loaded    = 1'b0;
		errors    = 0;
		num_tests = 0;
		max_delay = 0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			m_awid[m]    = '0;
			m_awaddr[m]  = '0;
			m_awlen[m]   = '0;
			m_awsize[m]  = '0;
			m_awburst[m] = '0;
			m_awvalid[m] = 1'b0;
		end
		for (int s = 0; s < NUM_SLAVES; s++) begin
			s_awready[s] = 1'b0;
			cur_delay[s] = 0;
		end
		load_tests();
		loaded = 1'b1;
		repeat (2) @(posedge aclk);
		rst_n <= 1'b1;
		for (int t = 0; t < num_tests; t++) run_test(t);
		$display("tests run: %0d, errors: %0d", num_tests, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- design/aw_xbar_top.sv
`timescale 1ns/1ns
`default_nettype none

module aw_xbar_top (
	input  wire                              aclk,
	input  wire                              rst_n,
	// Masters
	input  wire axi_xbar_pkg::axi_id_t       m_awid    [axi_xbar_pkg::NUM_MASTERS],
	input  wire axi_xbar_pkg::axi_addr_t     m_awaddr  [axi_xbar_pkg::NUM_MASTERS],
	input  wire axi_xbar_pkg::axi_len_t      m_awlen   [axi_xbar_pkg::NUM_MASTERS],
	input  wire axi_xbar_pkg::axi_size_t     m_awsize  [axi_xbar_pkg::NUM_MASTERS],
	input  wire axi_xbar_pkg::axi_burst_t    m_awburst [axi_xbar_pkg::NUM_MASTERS],
	input  wire                              m_awvalid [axi_xbar_pkg::NUM_MASTERS],
	output logic                             m_awready [axi_xbar_pkg::NUM_MASTERS],
	// Slaves
	output axi_xbar_pkg::axi_ids_t           s_awid    [axi_xbar_pkg::NUM_SLAVES],
	output axi_xbar_pkg::axi_addr_t          s_awaddr  [axi_xbar_pkg::NUM_SLAVES],
	output axi_xbar_pkg::axi_len_t           s_awlen   [axi_xbar_pkg::NUM_SLAVES],
	output axi_xbar_pkg::axi_size_t          s_awsize  [axi_xbar_pkg::NUM_SLAVES],
	output axi_xbar_pkg::axi_burst_t         s_awburst [axi_xbar_pkg::NUM_SLAVES],
	output logic                             s_awvalid [axi_xbar_pkg::NUM_SLAVES],
	input  wire                              s_awready [axi_xbar_pkg::NUM_SLAVES],
	// Decode error
	output logic                             decerr,
	output axi_xbar_pkg::master_idx_t        decerr_master
);
	import axi_xbar_pkg::*;

	slave_idx_t             target [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] hit;
	logic [NUM_MASTERS-1:0] req;
	logic                   grant_valid;
	master_idx_t            grant;
	logic                   done;

	aw_if #(.ID_W(ID_BITS))          m_if [NUM_MASTERS] ();
	aw_if #(.ID_W($bits(axi_ids_t))) s_if [NUM_SLAVES] ();

	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_mst
		assign m_if[m].id    = m_awid[m];
		assign m_if[m].addr  = m_awaddr[m];
		assign m_if[m].len   = m_awlen[m];
		assign m_if[m].size  = m_awsize[m];
		assign m_if[m].burst = m_awburst[m];
		assign m_if[m].valid = m_awvalid[m];
		assign m_awready[m]  = m_if[m].ready;
		assign req[m]        = m_awvalid[m];
	end

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slv
		assign s_awid[s]     = s_if[s].id;
		assign s_awaddr[s]   = s_if[s].addr;
		assign s_awlen[s]    = s_if[s].len;
		assign s_awsize[s]   = s_if[s].size;
		assign s_awburst[s]  = s_if[s].burst;
		assign s_awvalid[s]  = s_if[s].valid;
		assign s_if[s].ready = s_awready[s];
	end

	aw_addr_decoder i_decoder (
		.addr   (m_awaddr),
		.target (target),
		.hit    (hit)
	);

	aw_arbiter i_arbiter (
		.aclk        (aclk),
		.rst_n       (rst_n),
		.req         (req),
		.done        (done),
		.grant_valid (grant_valid),
		.grant       (grant)
	);

	write_address_channel i_channel (
		.aclk          (aclk),
		.rst_n         (rst_n),
		.mst           (m_if),
		.slv           (s_if),
		.grant_valid   (grant_valid),
		.grant         (grant),
		.target        (target),
		.hit           (hit),
		.done          (done),
		.decerr        (decerr),
		.decerr_master (decerr_master)
	);

endmodule

`default_nettype wire

//--- design/write_address_channel.sv
`timescale 1ns/1ns
`default_nettype none

module write_address_channel (
	input  wire                                  aclk,
	input  wire                                  rst_n,
	aw_if.slave                                  mst [axi_xbar_pkg::NUM_MASTERS],
	aw_if.master                                 slv [axi_xbar_pkg::NUM_SLAVES],
	input  wire                                  grant_valid,
	input  wire axi_xbar_pkg::master_idx_t       grant,
	input  wire axi_xbar_pkg::slave_idx_t        target [axi_xbar_pkg::NUM_MASTERS],
	input  wire [axi_xbar_pkg::NUM_MASTERS-1:0]  hit,
	output logic                                 done,
	output logic                                 decerr,
	output axi_xbar_pkg::master_idx_t            decerr_master
);
	import axi_xbar_pkg::*;

	axi_id_t                m_id    [NUM_MASTERS];
	axi_addr_t              m_addr  [NUM_MASTERS];
	axi_len_t               m_len   [NUM_MASTERS];
	axi_size_t              m_size  [NUM_MASTERS];
	axi_burst_t             m_burst [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] m_valid;
	logic [NUM_SLAVES-1:0]  s_ready;
	logic [NUM_SLAVES-1:0]  s_sel;
	logic [NUM_SLAVES-1:0]  s_valid;

	axi_ids_t   sel_id;
	axi_addr_t  sel_addr;
	axi_len_t   sel_len;
	axi_size_t  sel_size;
	axi_burst_t sel_burst;
	slave_idx_t sel_target;
	logic       sel_hit;
	logic       sel_valid;
	logic       ready_sel;
	logic       started;
	logic       first_cycle;

	// Master side: flatten fields, return ready to the granted one only
	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_mst
		assign m_id[m]    = mst[m].id;
		assign m_addr[m]  = mst[m].addr;
		assign m_len[m]   = mst[m].len;
		assign m_size[m]  = mst[m].size;
		assign m_burst[m] = mst[m].burst;
		assign m_valid[m] = mst[m].valid;
		assign mst[m].ready = grant_valid && (grant == m) && ready_sel;
	end

	// Granted request
	assign sel_id     = {grant, m_id[grant]};
	assign sel_addr   = m_addr[grant];
	assign sel_len    = m_len[grant];
	assign sel_size   = m_size[grant];
	assign sel_burst  = m_burst[grant];
	assign sel_valid  = m_valid[grant];
	assign sel_target = target[grant];
	assign sel_hit    = hit[grant];

	// Set after the first busy cycle, cleared once the transfer is done
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			started <= 1'b0;
		end else begin
			started <= grant_valid && !done;
		end
	end

	assign first_cycle = grant_valid && !started;

	// Unmapped requests are accepted locally, once
	assign ready_sel = sel_hit ? s_ready[sel_target] : first_cycle;
	assign done      = grant_valid &&
	                   (sel_hit ? (sel_valid && s_ready[sel_target]) : first_cycle);

	assign decerr        = first_cycle && !sel_hit;
	assign decerr_master = grant;

	// Slave side: only the decoded target sees the request
	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slv
		assign s_ready[s] = slv[s].ready;
		assign s_sel[s]   = grant_valid && sel_hit && (sel_target == s);
		assign s_valid[s] = s_sel[s] && sel_valid;

		assign slv[s].valid = s_valid[s];
		assign slv[s].id    = s_sel[s] ? sel_id    : '0;
		assign slv[s].addr  = s_sel[s] ? sel_addr  : '0;
		assign slv[s].len   = s_sel[s] ? sel_len   : '0;
		assign slv[s].size  = s_sel[s] ? sel_size  : '0;
		assign slv[s].burst = s_sel[s] ? sel_burst : '0;
	end

	// One transfer in flight across all slaves
	a_one_slave: assert property (
		@(posedge aclk) disable iff (!rst_n)
		$onehot0(s_valid)
	) else $error("more than one slave valid: %b", s_valid);

endmodule

`default_nettype wire

//--- design/aw_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module aw_arbiter (
	input  wire                                  aclk,
	input  wire                                  rst_n,
	input  wire [axi_xbar_pkg::NUM_MASTERS-1:0]  req,
	input  wire                                  done,
	output logic                                 grant_valid,
	output axi_xbar_pkg::master_idx_t            grant
);
	import axi_xbar_pkg::*;

	arb_state_t  state;
	master_idx_t next_grant;
	logic        found;

	// Search starts one past the last grant and wraps around
	always_comb begin
		int idx;

		next_grant = grant;
		found      = 1'b0;
		for (int off = 1; off <= NUM_MASTERS; off++) begin
			idx = (int'(grant) + off) % NUM_MASTERS;
			if (!found && req[idx]) begin
				next_grant = master_idx_t'(idx);
				found      = 1'b1;
			end
		end
	end

	// Grant register also serves as the round-robin pointer
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state <= ARB_IDLE;
			// Last master, so master 0 wins first
			grant <= master_idx_t'(NUM_MASTERS - 1);
		end else begin
			case (state)
				ARB_IDLE: begin
					if (found) begin
						grant <= next_grant;
						state <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					if (done) begin
						state <= ARB_IDLE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	assign grant_valid = (state == ARB_BUSY);

	// Grant held for the whole transfer
	a_grant_stable: assert property (
		@(posedge aclk) disable iff (!rst_n)
		grant_valid |=> $stable(grant)
	) else $error("grant changed while busy");

	// Granted master must keep valid until the channel completes it
	a_req_held: assert property (
		@(posedge aclk) disable iff (!rst_n)
		grant_valid |-> req[grant]
	) else $error("master %0d dropped valid before acceptance", grant);

endmodule

`default_nettype wire

//--- design/aw_addr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module aw_addr_decoder (
	input  wire axi_xbar_pkg::axi_addr_t  addr   [axi_xbar_pkg::NUM_MASTERS],
	output axi_xbar_pkg::slave_idx_t      target [axi_xbar_pkg::NUM_MASTERS],
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0] hit
);
	import axi_xbar_pkg::*;

	// One bit per master and region
	logic [NUM_SLAVES-1:0] match [NUM_MASTERS];

	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_mst

		for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_rgn
			assign match[m][s] = ((addr[m] & SLAVE_MASK[s]) == SLAVE_BASE[s]);
		end

		// Encode the matching region
		always_comb begin
			target[m] = '0;
			for (int s = 0; s < NUM_SLAVES; s++) begin
				if (match[m][s]) begin
					target[m] = slave_idx_t'(s);
				end
			end
		end

		// No region, no slave
		assign hit[m] = |match[m];

		// Overlapping regions would make the route ambiguous
		always_comb begin
			a_one_region: assert final ($onehot0(match[m]))
			else $error("addr %h of master %0d hits more than one region", addr[m], m);
		end

	end

endmodule

`default_nettype wire

//--- design/aw_if.sv
`timescale 1ns/1ns
`default_nettype none

interface aw_if #(
	parameter int ID_W = axi_xbar_pkg::ID_BITS
);
	import axi_xbar_pkg::*;

	logic [ID_W-1:0] id;
	axi_addr_t       addr;
	axi_len_t        len;
	axi_size_t       size;
	axi_burst_t      burst;
	logic            valid;
	logic            ready;

	// Issuing side of the channel
	modport master (
		output id, addr, len, size, burst, valid,
		input  ready
	);

	modport slave (
		input  id, addr, len, size, burst, valid,
		output ready
	);

endinterface

`default_nettype wire

//--- design/axi_xbar_pkg.sv
`default_nettype none

package axi_xbar_pkg;

	localparam int NUM_MASTERS = 3;
	localparam int NUM_SLAVES  = 4;
	localparam int ADDR_BITS   = 32;
	localparam int ID_BITS     = 4;
	localparam int LEN_BITS    = 4;
	localparam int SIZE_BITS   = 3;
	localparam int MID_BITS    = 2;
	localparam int SID_BITS    = 2;

	typedef logic [ADDR_BITS-1:0]        axi_addr_t;
	typedef logic [ID_BITS-1:0]          axi_id_t;
	// Master number on top of the master id
	typedef logic [ID_BITS+MID_BITS-1:0] axi_ids_t;
	typedef logic [LEN_BITS-1:0]         axi_len_t;
	typedef logic [SIZE_BITS-1:0]        axi_size_t;
	typedef logic [1:0]                  axi_burst_t;
	typedef logic [MID_BITS-1:0]         master_idx_t;
	typedef logic [SID_BITS-1:0]         slave_idx_t;

	// Two 64 KB regions low, two 256 MB regions above
	localparam axi_addr_t SLAVE_BASE [NUM_SLAVES] = '{
		32'h0000_0000,
		32'h0001_0000,
		32'h1000_0000,
		32'h2000_0000
	};
	localparam axi_addr_t SLAVE_MASK [NUM_SLAVES] = '{
		32'hffff_0000,
		32'hffff_0000,
		32'hf000_0000,
		32'hf000_0000
	};

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

endpackage

`default_nettype wire
